// ==== logic/sm83_pkg.sv ====
`default_nettype none

package sm83_pkg;

    localparam int STEP_W = 3;

    // One opcode byte, seen as r8 fields or as an r16 pair field
    typedef union packed {
        struct packed {
            logic [1:0] blk;
            logic [2:0] dst;
            logic [2:0] src;
        } r;
        struct packed {
            logic [1:0] blk;
            logic [1:0] pair;
            logic       q;
            logic [2:0] low;
        } p;
    } opcode_u;

    // Register file slots, NONE and MEM are bus markers only
    typedef enum logic [3:0] {
        NONE = 4'd0,
        B    = 4'd1,
        C    = 4'd2,
        D    = 4'd3,
        E    = 4'd4,
        H    = 4'd5,
        L    = 4'd6,
        A    = 4'd7,
        Z    = 4'd8,
        W    = 4'd9,
        PCH  = 4'd10,
        PCL  = 4'd11,
        MEM  = 4'd15
    } reg8_t;

    typedef enum logic [2:0] {
        WZ,
        BC,
        DE,
        HL,
        PC
    } pair_t;

    typedef enum logic [1:0] {
        NO_MASK,
        OR_FF00,
        ZERO
    } ab_mask_t;

    // Order follows the opcode's ALU field
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_SBC,
        ALU_AND,
        ALU_XOR,
        ALU_OR,
        ALU_CP
    } alu_op_t;

    typedef enum logic {
        R_WB_DB,
        R_WB_ALU
    } r_wb_t;

    typedef enum logic [1:0] {
        RR_WB_NONE,
        RR_WB_INC,
        RR_WB_WZ
    } rr_wb_t;

    typedef enum logic {
        ACC_A,
        ACC_DB
    } acc_t;

    typedef struct packed {
        logic z;
        logic n;
        logic h;
        logic c;
    } flags_t;

endpackage

`default_nettype wire

// ==== logic/fetch_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_sequencer (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        ce,
    input  wire logic                        done,
    input  wire logic [7:0]                  mem_in,
    output sm83_pkg::opcode_u                ir,
    output logic      [sm83_pkg::STEP_W-1:0] step
);

    // The last step of every instruction reads the next opcode at PC
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ir   <= sm83_pkg::opcode_u'(8'h00);  // NOP
            step <= '0;
        end else if (ce) begin
            if (done) begin
                ir   <= sm83_pkg::opcode_u'(mem_in);
                step <= '0;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

    // Longest kept instruction is JP nn, four steps
    a_step_range: assert property (@(posedge clk) disable iff (!rst)
        ce |-> step <= sm83_pkg::STEP_W'(3))
        else $error("step counter ran past the last step of JP nn");

endmodule

`default_nettype wire

// ==== logic/step_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module step_decoder (
    input  wire sm83_pkg::opcode_u                ir,
    input  wire logic [sm83_pkg::STEP_W-1:0]      step,
    output logic                                  done,
    output sm83_pkg::reg8_t                       src8,
    output sm83_pkg::reg8_t                       dst8,
    output sm83_pkg::pair_t                       addr_src,
    output sm83_pkg::ab_mask_t                    ab_mask,
    output sm83_pkg::r_wb_t                       r_wb,
    output sm83_pkg::rr_wb_t                      rr_wb,
    output sm83_pkg::pair_t                       rr_dst,
    output sm83_pkg::alu_op_t                     alu_op,
    output sm83_pkg::acc_t                        acc_sel,
    output logic                                  wr_pc,
    output logic                                  wr_flags
);

    function automatic sm83_pkg::reg8_t r8_of(input logic [2:0] f);
        case (f)
            3'd0:    return sm83_pkg::B;
            3'd1:    return sm83_pkg::C;
            3'd2:    return sm83_pkg::D;
            3'd3:    return sm83_pkg::E;
            3'd4:    return sm83_pkg::H;
            3'd5:    return sm83_pkg::L;
            3'd6:    return sm83_pkg::MEM;  // (HL)
            default: return sm83_pkg::A;
        endcase
    endfunction

    logic [1:0]        blk;
    logic              dst_hl;
    logic              src_hl;
    sm83_pkg::reg8_t   r_dst;
    sm83_pkg::reg8_t   r_src;
    sm83_pkg::pair_t   r_pair;
    sm83_pkg::alu_op_t alu_fn;
    logic              is_ld_rr_nn;
    logic              is_ld_r_n;
    logic              is_incdec;
    logic              is_ld_r_r;
    logic              is_ld_hl_r;
    logic              is_ld_r_hl;
    logic              is_alu_r;
    logic              is_alu_hl;
    logic              is_alu_n;
    logic              is_jp;
    logic              is_ldh_w;
    logic              is_ldh_r;
    logic              two_step;  // Operand goes through Z first
    logic              from_hl;

    assign blk    = ir.r.blk;
    assign dst_hl = ir.r.dst == 3'd6;
    assign src_hl = ir.r.src == 3'd6;
    assign r_dst  = r8_of(ir.r.dst);
    assign r_src  = r8_of(ir.r.src);
    assign alu_fn = sm83_pkg::alu_op_t'(ir.r.dst);
    assign r_pair = (ir.p.pair == 2'd0) ? sm83_pkg::BC :
                    (ir.p.pair == 2'd1) ? sm83_pkg::DE : sm83_pkg::HL;

    // Pair 3 is SP, which this core does not have
    assign is_ld_rr_nn = blk == 2'd0 && !ir.p.q && ir.p.low == 3'd1 && ir.p.pair != 2'd3;
    assign is_ld_r_n   = blk == 2'd0 && src_hl && !dst_hl;
    assign is_incdec   = blk == 2'd0 && ir.r.src[2:1] == 2'b10 && !dst_hl;
    assign is_ld_r_r   = blk == 2'd1 && !dst_hl && !src_hl;
    assign is_ld_hl_r  = blk == 2'd1 && dst_hl && !src_hl;
    assign is_ld_r_hl  = blk == 2'd1 && src_hl && !dst_hl;
    assign is_alu_r    = blk == 2'd2 && !src_hl;
    assign is_alu_hl   = blk == 2'd2 && src_hl;
    assign is_alu_n    = blk == 2'd3 && src_hl;
    assign is_jp       = ir == 8'hc3;
    assign is_ldh_w    = ir == 8'he0;
    assign is_ldh_r    = ir == 8'hf0;

    assign two_step = is_ld_r_n || is_ld_r_hl || is_alu_hl || is_alu_n;
    assign from_hl  = is_ld_r_hl || is_alu_hl;

    always_comb begin
        done     = 1'b0;
        src8     = sm83_pkg::NONE;
        dst8     = sm83_pkg::NONE;
        addr_src = sm83_pkg::PC;
        ab_mask  = sm83_pkg::NO_MASK;
        r_wb     = sm83_pkg::R_WB_DB;
        rr_wb    = sm83_pkg::RR_WB_NONE;
        rr_dst   = sm83_pkg::WZ;
        alu_op   = alu_fn;
        acc_sel  = sm83_pkg::ACC_A;
        wr_pc    = 1'b0;
        wr_flags = 1'b0;

        if (two_step && step == '0) begin
            addr_src = from_hl ? sm83_pkg::HL : sm83_pkg::PC;
            wr_pc    = !from_hl;  // Immediate byte advances PC
            src8     = sm83_pkg::MEM;
            dst8     = sm83_pkg::Z;
        end else if (is_ld_r_r || is_ld_r_n || is_ld_r_hl) begin
            src8 = two_step ? sm83_pkg::Z : r_src;
            dst8 = r_dst;
            done = 1'b1;
        end else if (is_alu_r || is_alu_hl || is_alu_n) begin
            src8     = two_step ? sm83_pkg::Z : r_src;
            dst8     = (alu_fn == sm83_pkg::ALU_CP) ? sm83_pkg::NONE : sm83_pkg::A;
            r_wb     = sm83_pkg::R_WB_ALU;
            wr_flags = 1'b1;
            done     = 1'b1;
        end else if (is_incdec) begin
            src8     = r_dst;
            dst8     = r_dst;
            acc_sel  = sm83_pkg::ACC_DB;
            alu_op   = ir.r.src[0] ? sm83_pkg::ALU_SUB : sm83_pkg::ALU_ADD;
            r_wb     = sm83_pkg::R_WB_ALU;
            wr_flags = 1'b1;
            done     = 1'b1;
        end else if (is_ld_hl_r) begin
            if (step == '0) begin
                addr_src = sm83_pkg::HL;
                src8     = r_src;
                dst8     = sm83_pkg::MEM;
            end else begin
                done = 1'b1;
            end
        end else if (is_ld_rr_nn || is_jp || is_ldh_w || is_ldh_r) begin
            case (step)
                3'd0: begin  // Z from the byte after the opcode
                    wr_pc = 1'b1;
                    src8  = sm83_pkg::MEM;
                    dst8  = sm83_pkg::Z;
                end
                3'd1: begin
                    if (is_ldh_w || is_ldh_r) begin
                        addr_src = sm83_pkg::WZ;
                        ab_mask  = sm83_pkg::OR_FF00;  // High page FF00 + n
                        src8     = is_ldh_w ? sm83_pkg::A : sm83_pkg::MEM;
                        dst8     = is_ldh_w ? sm83_pkg::MEM : sm83_pkg::A;
                    end else begin
                        wr_pc = 1'b1;
                        src8  = sm83_pkg::MEM;
                        dst8  = sm83_pkg::W;
                    end
                end
                3'd2: begin
                    if (is_jp) begin
                        ab_mask = sm83_pkg::ZERO;  // Bus idle while PC is reloaded
                        rr_wb   = sm83_pkg::RR_WB_WZ;
                        rr_dst  = sm83_pkg::PC;
                    end else begin
                        rr_wb  = is_ld_rr_nn ? sm83_pkg::RR_WB_WZ : sm83_pkg::RR_WB_NONE;
                        rr_dst = r_pair;
                        done   = 1'b1;
                    end
                end
                default: done = 1'b1;
            endcase
        end else begin
            done = 1'b1;  // NOP, HALT and everything dropped
        end

        // Closing step of every instruction fetches the next opcode
        if (done) begin
            addr_src = sm83_pkg::PC;
            ab_mask  = sm83_pkg::NO_MASK;
            wr_pc    = 1'b1;
        end
    end

    always_comb begin
        a_no_zero_store: assert (!(dst8 == sm83_pkg::MEM && ab_mask == sm83_pkg::ZERO))
            else $error("store row selects the zeroed address bus");
    end

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_file #(
    parameter logic [15:0] RESET_PC = 16'h0000
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             ce,
    input  wire logic [7:0]       mem_in,
    input  wire sm83_pkg::reg8_t  src8,
    input  wire sm83_pkg::reg8_t  dst8,
    input  wire sm83_pkg::pair_t  addr_src,
    input  wire sm83_pkg::r_wb_t  r_wb,
    input  wire sm83_pkg::rr_wb_t rr_wb,
    input  wire sm83_pkg::pair_t  rr_dst,
    input  wire sm83_pkg::acc_t   acc_sel,
    input  wire logic             wr_pc,
    input  wire logic             wr_flags,
    input  wire logic [7:0]       alu_res,
    input  wire sm83_pkg::flags_t alu_flags,
    input  wire logic [15:0]      inc_val,
    output logic      [7:0]       db,
    output logic      [7:0]       acc,
    output logic      [15:0]      pair_val,
    output sm83_pkg::flags_t      flags
);

    logic [7:0]  rf [sm83_pkg::B:sm83_pkg::PCL];
    logic [7:0]  src_val;
    logic [7:0]  wb_val;
    logic [15:0] rr_val;

    always_comb begin
        case (src8)
            sm83_pkg::MEM:  src_val = mem_in;  // Read data is used in the same cycle
            sm83_pkg::NONE: src_val = 8'h00;
            default:        src_val = rf[src8];
        endcase
    end

    // Inc/dec feed the operand on the accumulator side and one on the bus
    assign acc = (acc_sel == sm83_pkg::ACC_A) ? rf[sm83_pkg::A] : src_val;
    assign db  = (acc_sel == sm83_pkg::ACC_DB) ? 8'h01 : src_val;

    assign wb_val = (r_wb == sm83_pkg::R_WB_ALU) ? alu_res : db;
    assign rr_val = (rr_wb == sm83_pkg::RR_WB_INC) ? inc_val
                                                   : {rf[sm83_pkg::W], rf[sm83_pkg::Z]};

    always_comb begin
        case (addr_src)
            sm83_pkg::WZ: pair_val = {rf[sm83_pkg::W], rf[sm83_pkg::Z]};
            sm83_pkg::BC: pair_val = {rf[sm83_pkg::B], rf[sm83_pkg::C]};
            sm83_pkg::DE: pair_val = {rf[sm83_pkg::D], rf[sm83_pkg::E]};
            sm83_pkg::HL: pair_val = {rf[sm83_pkg::H], rf[sm83_pkg::L]};
            default:      pair_val = {rf[sm83_pkg::PCH], rf[sm83_pkg::PCL]};
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = sm83_pkg::B; i <= sm83_pkg::PCL; i++) begin
                rf[i] <= 8'h00;
            end
            rf[sm83_pkg::PCH] <= RESET_PC[15:8];
            rf[sm83_pkg::PCL] <= RESET_PC[7:0];
            flags             <= '0;
        end else if (ce) begin
            if (rr_wb != sm83_pkg::RR_WB_NONE) begin
                case (rr_dst)
                    sm83_pkg::WZ: {rf[sm83_pkg::W], rf[sm83_pkg::Z]} <= rr_val;
                    sm83_pkg::BC: {rf[sm83_pkg::B], rf[sm83_pkg::C]} <= rr_val;
                    sm83_pkg::DE: {rf[sm83_pkg::D], rf[sm83_pkg::E]} <= rr_val;
                    sm83_pkg::HL: {rf[sm83_pkg::H], rf[sm83_pkg::L]} <= rr_val;
                    default:      {rf[sm83_pkg::PCH], rf[sm83_pkg::PCL]} <= rr_val;
                endcase
            end
            if (dst8 != sm83_pkg::NONE && dst8 != sm83_pkg::MEM) begin
                rf[dst8] <= wb_val;
            end
            if (wr_pc) begin
                {rf[sm83_pkg::PCH], rf[sm83_pkg::PCL]} <= inc_val;  // addr + 1
            end
            if (wr_flags) begin
                flags <= alu_flags;
            end
        end
    end

    // The incrementer and a WZ reload never target PC in the same cycle
    a_one_pc_source: assert property (@(posedge clk) disable iff (!rst)
        (ce && wr_pc) |-> !(rr_wb != sm83_pkg::RR_WB_NONE && rr_dst == sm83_pkg::PC))
        else $error("PC loaded from the incrementer and a pair at once");

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire sm83_pkg::alu_op_t op,
    input  wire logic [7:0]        acc,
    input  wire logic [7:0]        arg,
    input  wire logic              c_in,
    output logic      [7:0]        res,
    output sm83_pkg::flags_t       f_out
);

    logic       sub;
    logic       cy;
    logic [7:0] arg_x;
    logic       half;
    logic       full;
    logic [7:0] sum;

    assign sub   = op inside {sm83_pkg::ALU_SUB, sm83_pkg::ALU_SBC, sm83_pkg::ALU_CP};
    assign arg_x = sub ? ~arg : arg;  // Subtract as add of the complement

    always_comb begin
        case (op)
            sm83_pkg::ALU_ADC:                  cy = c_in;
            sm83_pkg::ALU_SBC:                  cy = ~c_in;
            sm83_pkg::ALU_SUB, sm83_pkg::ALU_CP: cy = 1'b1;
            default:                            cy = 1'b0;
        endcase
    end

    // Nibbles added apart so the half carry falls out directly
    assign {half, sum[3:0]} = {1'b0, acc[3:0]} + {1'b0, arg_x[3:0]} + {4'b0, cy};
    assign {full, sum[7:4]} = {1'b0, acc[7:4]} + {1'b0, arg_x[7:4]} + {4'b0, half};

    always_comb begin
        case (op)
            sm83_pkg::ALU_AND: res = acc & arg;
            sm83_pkg::ALU_XOR: res = acc ^ arg;
            sm83_pkg::ALU_OR:  res = acc | arg;
            default:           res = sum;  // CP keeps only the flags
        endcase
        f_out.z = res == 8'h00;
        if (op inside {sm83_pkg::ALU_AND, sm83_pkg::ALU_XOR, sm83_pkg::ALU_OR}) begin
            f_out.n = 1'b0;
            f_out.h = 1'b0;
            f_out.c = 1'b0;
        end else begin
            f_out.n = sub;
            f_out.h = half ^ sub;  // Borrow is the inverted carry
            f_out.c = full ^ sub;
        end
    end

endmodule

`default_nettype wire

// ==== logic/bus_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_unit (
    input  wire logic               rst,
    input  wire logic [15:0]        pair_val,
    input  wire sm83_pkg::ab_mask_t ab_mask,
    input  wire sm83_pkg::reg8_t    dst8,
    output logic      [15:0]        addr,
    output logic                    write,
    output logic      [15:0]        inc_val
);

    always_comb begin
        if (!rst) begin
            addr = 16'h0000;
        end else begin
            case (ab_mask)
                sm83_pkg::NO_MASK: addr = pair_val;
                sm83_pkg::OR_FF00: addr = pair_val | 16'hff00;
                default:           addr = 16'h0000;
            endcase
        end
    end

    assign write   = rst && dst8 == sm83_pkg::MEM;  // Store whenever the bus target is memory
    assign inc_val = addr + 16'd1;                  // PC advance and pair increment

    always_comb begin
        if (write) begin
            a_store_addr: assert (ab_mask != sm83_pkg::ZERO)
                else $error("write strobe with a zeroed address");
        end
    end

endmodule

`default_nettype wire

// ==== logic/sm83_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module sm83_core #(
    parameter logic [15:0] RESET_PC = 16'h0000
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        ce,
    input  wire logic [7:0]  d_in_ext,
    output logic      [15:0] addr,
    output logic      [7:0]  d_out,
    output logic             write
);

    sm83_pkg::opcode_u                ir;
    logic [sm83_pkg::STEP_W-1:0]      step;
    logic                             done;
    sm83_pkg::reg8_t                  src8;
    sm83_pkg::reg8_t                  dst8;
    sm83_pkg::pair_t                  addr_src;
    sm83_pkg::pair_t                  rr_dst;
    sm83_pkg::ab_mask_t               ab_mask;
    sm83_pkg::r_wb_t                  r_wb;
    sm83_pkg::rr_wb_t                 rr_wb;
    sm83_pkg::alu_op_t                alu_op;
    sm83_pkg::acc_t                   acc_sel;
    logic                             wr_pc;
    logic                             wr_flags;
    logic [7:0]                       db;
    logic [7:0]                       acc;
    logic [15:0]                      pair_val;
    logic [15:0]                      inc_val;
    logic [7:0]                       alu_res;
    sm83_pkg::flags_t                 alu_flags;
    sm83_pkg::flags_t                 flags;

    assign d_out = db;  // Stores always come from the internal data bus

    fetch_sequencer i_fetch_sequencer (
        .clk    (clk),
        .rst    (rst),
        .ce     (ce),
        .done   (done),
        .mem_in (d_in_ext),
        .ir     (ir),
        .step   (step)
    );

    step_decoder i_step_decoder (
        .ir       (ir),
        .step     (step),
        .done     (done),
        .src8     (src8),
        .dst8     (dst8),
        .addr_src (addr_src),
        .ab_mask  (ab_mask),
        .r_wb     (r_wb),
        .rr_wb    (rr_wb),
        .rr_dst   (rr_dst),
        .alu_op   (alu_op),
        .acc_sel  (acc_sel),
        .wr_pc    (wr_pc),
        .wr_flags (wr_flags)
    );

    register_file #(
        .RESET_PC (RESET_PC)
    ) i_register_file (
        .clk       (clk),
        .rst       (rst),
        .ce        (ce),
        .mem_in    (d_in_ext),
        .src8      (src8),
        .dst8      (dst8),
        .addr_src  (addr_src),
        .r_wb      (r_wb),
        .rr_wb     (rr_wb),
        .rr_dst    (rr_dst),
        .acc_sel   (acc_sel),
        .wr_pc     (wr_pc),
        .wr_flags  (wr_flags),
        .alu_res   (alu_res),
        .alu_flags (alu_flags),
        .inc_val   (inc_val),
        .db        (db),
        .acc       (acc),
        .pair_val  (pair_val),
        .flags     (flags)
    );

    alu i_alu (
        .op    (alu_op),
        .acc   (acc),
        .arg   (db),
        .c_in  (flags.c),
        .res   (alu_res),
        .f_out (alu_flags)
    );

    bus_unit i_bus_unit (
        .rst      (rst),
        .pair_val (pair_val),
        .ab_mask  (ab_mask),
        .dst8     (dst8),
        .addr     (addr),
        .write    (write),
        .inc_val  (inc_val)
    );

endmodule

`default_nettype wire

// ==== tests/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Program bytes, placed at RESET_PC and at the JP target
localparam logic [15:0] RESET_PC  = 16'h0100;
localparam logic [15:0] JP_TARGET = 16'h0200;
localparam int          MAIN_LEN  = 62;
localparam int          JP_LEN    = 12;

localparam logic [7:0] MAIN_CODE [MAIN_LEN] = '{
    8'h21, 8'h00, 8'hc0,  // LD HL,C000
    8'h06, 8'h3c,         // LD B,3C
    8'h0e, 8'hf1,         // LD C,F1
    8'h70,                // LD (HL),B
    8'h51,                // LD D,C
    8'h72,                // LD (HL),D
    8'h11, 8'h34, 8'h12,  // LD DE,1234
    8'h5a,                // LD E,D
    8'h73,                // LD (HL),E
    8'h74,                // LD (HL),H
    8'h3e, 8'h3a,         // LD A,3A
    8'h80, 8'h77,         // ADD A,B
    8'hc6, 8'hc5, 8'h77,  // ADD A,C5 sets carry
    8'h89, 8'h77,         // ADC A,C
    8'hd6, 8'h40, 8'h77,  // SUB A,40 borrows
    8'h9e, 8'h77,         // SBC A,(HL)
    8'ha0, 8'h77,         // AND A,B
    8'hee, 8'h5a, 8'h77,  // XOR A,5A
    8'hb1, 8'h77,         // OR A,C
    8'hfe, 8'hf8,         // CP A,F8 leaves A alone, sets carry
    8'hce, 8'h00, 8'h77,  // ADC A,00
    8'h9a, 8'h77,         // SBC A,D
    8'h86, 8'h77,         // ADD A,(HL)
    8'h06, 8'hff,         // LD B,FF
    8'h04, 8'h70,         // INC B wraps to 00
    8'h0e, 8'h00,         // LD C,00
    8'h0d, 8'h71,         // DEC C wraps to FF
    8'h3c, 8'h77,         // INC A
    8'hc3, 8'h00, 8'h02,  // JP 0200
    8'h3e, 8'h99, 8'h77   // Skipped by the jump
};

localparam logic [7:0] JP_CODE [JP_LEN] = '{
    8'he0, 8'h80,         // LDH (80),A
    8'h3e, 8'h00,         // LD A,00
    8'hf0, 8'h81,         // LDH A,(81)
    8'h77,                // LD (HL),A
    8'h00, 8'h76,         // NOP, HALT runs as NOP
    8'hc3, 8'h09, 8'h02   // JP 0209, parks the core
};

localparam logic [15:0] PRELOAD_ADDR = 16'hff81;
localparam logic [7:0]  PRELOAD_DATA = 8'ha7;

// Expected stores in order, address then data
localparam int          N_STORES = 20;
localparam logic [15:0] STORE_ADDR [N_STORES] = '{
    16'hc000, 16'hc000, 16'hc000, 16'hc000, 16'hc000,
    16'hc000, 16'hc000, 16'hc000, 16'hc000, 16'hc000,
    16'hc000, 16'hc000, 16'hc000, 16'hc000, 16'hc000,
    16'hc000, 16'hc000, 16'hc000, 16'hff80, 16'hc000
};
localparam logic [7:0]  STORE_DATA [N_STORES] = '{
    8'h3c, 8'hf1, 8'h12, 8'hc0, 8'h76,
    8'h3b, 8'h2d, 8'hed, 8'hff, 8'h3c,
    8'h66, 8'hf7, 8'hf8, 8'he6, 8'hcc,
    8'h00, 8'hff, 8'hcd, 8'hcd, 8'ha7
};

`endif

// ==== tests/tb_sm83_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_sm83_core;

    `include "tb_program.svh"

    localparam int STORE_TIMEOUT = 4000;  // Cycles allowed for the whole program

    logic        clk;
    logic        rst;
    logic        ce;
    logic [15:0] addr;
    logic [7:0]  d_out;
    logic        write;
    wire  [7:0]  d_in_ext;

    logic [7:0]  mem [0:65535];
    int          store_idx;
    int          errors;
    logic        started;  // Set after the first active cycle
    bit          timed_out;

    sm83_core #(
        .RESET_PC (RESET_PC)
    ) i_sm83_core (
        .clk      (clk),
        .rst      (rst),
        .ce       (ce),
        .d_in_ext (d_in_ext),
        .addr     (addr),
        .d_out    (d_out),
        .write    (write)
    );

    assign d_in_ext = mem[addr];  // Asynchronous read

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] <= 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
        end
        for (int i = 0; i < MAIN_LEN; i++) begin
            mem[RESET_PC + 16'(i)] <= MAIN_CODE[i];
        end
        for (int i = 0; i < JP_LEN; i++) begin
            mem[JP_TARGET + 16'(i)] <= JP_CODE[i];
        end
        mem[PRELOAD_ADDR] <= PRELOAD_DATA;
    end

    always @(posedge clk) begin
        if (rst && ce && write) begin
            mem[addr] <= d_out;
        end
    end

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            started   <= 1'b0;
            store_idx <= 0;
        end else if (ce) begin
            started <= 1'b1;
            if (write) begin
                store_idx <= store_idx + 1;
            end
        end
    end

    function automatic bit store_matches(int idx, logic [15:0] a, logic [7:0] d);
        if (idx >= N_STORES) begin
            return 1'b0;
        end
        return a == STORE_ADDR[idx] && d == STORE_DATA[idx];
    endfunction

    a_first_fetch: assert property (@(posedge clk) disable iff (!rst)
        (ce && !started) |-> (addr == RESET_PC && !write))
        else begin
            errors++;
            $display("FAIL %0t: first fetch at %h with write %b", $time, addr, write);
        end

    a_store_value: assert property (@(posedge clk) disable iff (!rst)
        (ce && write) |-> store_matches(store_idx, addr, d_out))
        else begin
            errors++;
            $display("FAIL %0t: store %0d wrote %h to %h", $time, store_idx, d_out, addr);
        end

    // A store strobe lasts one active cycle
    a_store_single: assert property (@(posedge clk) disable iff (!rst)
        (ce && write) |=> !write)
        else begin
            errors++;
            $display("FAIL %0t: write held past its active cycle", $time);
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst)
        ($past(rst) && !$past(ce)) |->
            (addr == $past(addr) && d_out == $past(d_out) && write == $past(write)))
        else begin
            errors++;
            $display("FAIL %0t: bus moved during a stall, addr %h", $time, addr);
        end

    initial begin
        int stall_left;
        int cycles;

        errors     = 0;
        timed_out  = 1'b0;
        stall_left = 0;
        void'($urandom(32'h1302f9e5));
        rst        = 1'b0;
        ce         = 1'b1;

        repeat (3) @(posedge clk);
        #2 rst = 1'b1;

        cycles = 0;
        while (store_idx < N_STORES && cycles < STORE_TIMEOUT) begin
            @(posedge clk);
            #2;
            if (stall_left > 0) begin
                ce = 1'b0;
                stall_left--;
            end else if ($urandom % 5 == 0) begin
                ce         = 1'b0;
                stall_left = $urandom % 4;  // Stretch of up to three more cycles
            end else begin
                ce = 1'b1;
            end
            cycles++;
        end
        if (store_idx < N_STORES) begin
            timed_out = 1'b1;
            $display("Timed out after %0d cycles waiting for the program's stores", cycles);
        end

        // Let the parked loop run to catch any stray store
        cycles = 0;
        while (cycles < 40) begin
            @(posedge clk);
            #2 ce = 1'b1;
            cycles++;
        end

        $display("errors %0d, stores %0d of %0d", errors, store_idx, N_STORES);
        if (errors == 0 && !timed_out && store_idx == N_STORES) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sm83_core.f ====
+incdir+tests
logic/sm83_pkg.sv
logic/fetch_sequencer.sv
logic/step_decoder.sv
logic/register_file.sv
logic/alu.sv
logic/bus_unit.sv
logic/sm83_core.sv
tests/tb_sm83_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator, run, and fail if the log reports a failure
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_sm83_core \
    -f sm83_core.f -o tb_sm83_core_sim > sim.log 2>&1 &&
    ./obj_dir/tb_sm83_core_sim >> sim.log 2>&1 ||
    echo "TEST FAIL" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0
